// ==== design/bridge_cfg_pkg.sv ====
// BAR table and sideband map are fixed here and must match the hard IP configuration of the build
package bridge_cfg_pkg;

   // Avalon read-return side
   localparam int NUM_BARS   = 6;
   localparam int RXM_DATA_W = 64;

   // One bit per BAR master, set when the BAR is implemented
   localparam logic [NUM_BARS-1:0] BAR_IMPLEMENTED = 6'b000101;   // BAR0 and BAR2 only

   // Configuration sideband from the hard IP
   localparam int CFG_ADDR_W = 4;
   localparam int CFG_DATA_W = 32;

   // Sideband addresses that carry a shadowed field
   localparam logic [CFG_ADDR_W-1:0] CFG_A_DEVCSR         = 4'd0;    // Device control/status
   localparam logic [CFG_ADDR_W-1:0] CFG_A_PRMCSR         = 4'd3;    // Command register
   localparam logic [CFG_ADDR_W-1:0] CFG_A_MSI_ADDR_L     = 4'd5;    // MSI address [11:0]
   localparam logic [CFG_ADDR_W-1:0] CFG_A_MSI_ADDR_UL    = 4'd6;    // MSI address [43:32]
   localparam logic [CFG_ADDR_W-1:0] CFG_A_MSI_ADDR_H     = 4'd9;    // MSI address [31:12]
   localparam logic [CFG_ADDR_W-1:0] CFG_A_MSI_ADDR_UH    = 4'd11;   // MSI address [63:44]
   localparam logic [CFG_ADDR_W-1:0] CFG_A_MSI_CTL        = 4'd13;   // MSI and MSI-X control
   localparam logic [CFG_ADDR_W-1:0] CFG_A_BUSDEV_MSIDATA = 4'd15;   // Bus/device plus MSI data

   // Captured field widths
   localparam int BUSDEV_W   = 13;
   localparam int MSI_ADDR_W = 64;
   localparam int MSI_DATA_W = 16;
   localparam int MSIX_CTL_W = 16;

   // Packed MSI bus is address, data, MSI enable and bus master enable
   localparam int MSI_INTFC_W = MSI_ADDR_W + MSI_DATA_W + 2;   // 82

   // Bus master enable inside the captured command register
   localparam int MASTER_EN_BIT = 2;

endpackage

// ==== design/reset_sync.sv ====
// Reset assertion is immediate and needs no clock, release lands on the second AvlClk_i edge
module reset_sync
(
   input  logic AvlClk_i,
   input  logic Rstn_i,
   output logic rstn_reg_o
);

   logic rstn_meta;   // First stage, may go metastable on release
   logic rstn_sync;

   always_ff @(posedge AvlClk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
      begin
         rstn_meta <= 1'b0;
         rstn_sync <= 1'b0;
      end
      else
      begin
         rstn_meta <= 1'b1;
         rstn_sync <= rstn_meta;
      end
   end

   assign rstn_reg_o = rstn_sync;

   // Internal reset never lags the pad reset going low
   a_rst_follows_pad: assert property (@(posedge AvlClk_i) !Rstn_i |-> !rstn_reg_o)
      else $error("reset_sync: internal reset released while Rstn_i is low");

endmodule

// ==== design/cfg_shadow_capture.sv ====
// Sideband is sampled every cycle with no strobe, so the hard IP must hold CfgCtl_i valid per address
module cfg_shadow_capture
(
   input  logic                                  AvlClk_i,
   input  logic                                  rstn_i,
   input  logic [bridge_cfg_pkg::CFG_ADDR_W-1:0] CfgAddr_i,
   input  logic [bridge_cfg_pkg::CFG_DATA_W-1:0] CfgCtl_i,
   output logic [bridge_cfg_pkg::BUSDEV_W-1:0]   BusDev_o,
   output logic [bridge_cfg_pkg::CFG_DATA_W-1:0] dev_csr_o,
   output logic [15:0]                           prmcsr_o,
   output logic [15:0]                           msi_ctl_o,
   output logic [bridge_cfg_pkg::MSIX_CTL_W-1:0] msix_ctl_o,
   output logic [bridge_cfg_pkg::MSI_ADDR_W-1:0] msi_addr_o,
   output logic [bridge_cfg_pkg::MSI_DATA_W-1:0] msi_data_o
);

   import bridge_cfg_pkg::*;

   // Address decode
   logic sel_devcsr;
   logic sel_prmcsr;
   logic sel_addr_l;
   logic sel_addr_ul;
   logic sel_addr_h;
   logic sel_addr_uh;
   logic sel_msi_ctl;
   logic sel_busdev;

   assign sel_devcsr  = (CfgAddr_i == CFG_A_DEVCSR);
   assign sel_prmcsr  = (CfgAddr_i == CFG_A_PRMCSR);
   assign sel_addr_l  = (CfgAddr_i == CFG_A_MSI_ADDR_L);
   assign sel_addr_ul = (CfgAddr_i == CFG_A_MSI_ADDR_UL);
   assign sel_addr_h  = (CfgAddr_i == CFG_A_MSI_ADDR_H);
   assign sel_addr_uh = (CfgAddr_i == CFG_A_MSI_ADDR_UH);
   assign sel_msi_ctl = (CfgAddr_i == CFG_A_MSI_CTL);
   assign sel_busdev  = (CfgAddr_i == CFG_A_BUSDEV_MSIDATA);   // Also carries MSI data

   // Device CSR and command register
   always_ff @(posedge AvlClk_i or negedge rstn_i)
   begin
      if (!rstn_i)
      begin
         dev_csr_o <= '0;
         prmcsr_o  <= '0;
      end
      else
      begin
         if (sel_devcsr)
            dev_csr_o <= {16'h0, CfgCtl_i[31:16]};   // Status/control sits in the upper half
         if (sel_prmcsr)
            prmcsr_o <= CfgCtl_i[23:8];
      end
   end

   // Bus/device number and the MSI/MSI-X control words
   always_ff @(posedge AvlClk_i or negedge rstn_i)
   begin
      if (!rstn_i)
      begin
         BusDev_o   <= '0;
         msi_data_o <= '0;
         msi_ctl_o  <= '0;
         msix_ctl_o <= '0;
      end
      else
      begin
         if (sel_busdev)
         begin
            BusDev_o   <= CfgCtl_i[BUSDEV_W-1:0];
            msi_data_o <= CfgCtl_i[31:16];
         end
         if (sel_msi_ctl)
         begin
            msi_ctl_o  <= CfgCtl_i[15:0];
            msix_ctl_o <= CfgCtl_i[31:16];
         end
      end
   end

   // MSI address arrives in four slices at separate addresses
   always_ff @(posedge AvlClk_i or negedge rstn_i)
   begin
      if (!rstn_i)
         msi_addr_o <= '0;
      else
      begin
         if (sel_addr_l)
            msi_addr_o[11:0] <= CfgCtl_i[31:20];
         if (sel_addr_h)
            msi_addr_o[31:12] <= CfgCtl_i[31:12];
         if (sel_addr_ul)
            msi_addr_o[43:32] <= CfgCtl_i[31:20];
         if (sel_addr_uh)
            msi_addr_o[63:44] <= CfgCtl_i[31:12];
      end
   end

   // An X on a decoded address would otherwise surface only at the export two cycles later
   a_shadow_known: assert property (@(posedge AvlClk_i) disable iff (!rstn_i)
      !$isunknown({BusDev_o, dev_csr_o, prmcsr_o, msi_ctl_o, msix_ctl_o, msi_addr_o, msi_data_o}))
      else $error("cfg_shadow_capture: shadow register holds an unknown value");

endmodule

// ==== design/rxm_read_return_mux.sv ====
// Purely combinational, so the returned data path adds no cycle but also no retiming
module rxm_read_return_mux
(
   input  logic [bridge_cfg_pkg::NUM_BARS-1:0]                       RxmReadDataValid_i,
   input  logic [bridge_cfg_pkg::NUM_BARS-1:0]
                [bridge_cfg_pkg::RXM_DATA_W-1:0]                     RxmReadData_i,
   input  logic [bridge_cfg_pkg::NUM_BARS-1:0]                       RxmWaitRequest_i,
   output logic [bridge_cfg_pkg::NUM_BARS-1:0]                       rxm_wait_request_o,
   output logic                                                      RxmReadDataValid_o,
   output logic [bridge_cfg_pkg::RXM_DATA_W-1:0]                     RxmReadData_o
);

   import bridge_cfg_pkg::*;

   logic [NUM_BARS-1:0]   valid_masked;   // Valids of implemented BARs only
   logic                  valid_onehot;
   logic [RXM_DATA_W-1:0] data_sel;

   // Absent BARs never return data and always look busy
   assign valid_masked       = RxmReadDataValid_i & BAR_IMPLEMENTED;
   assign rxm_wait_request_o = RxmWaitRequest_i | ~BAR_IMPLEMENTED;

   assign RxmReadDataValid_o = |valid_masked;

   // Exactly one returning BAR
   assign valid_onehot = (valid_masked != '0) &&
                         ((valid_masked & (valid_masked - 1'b1)) == '0);

   always_comb
   begin
      data_sel = '0;
      for (int i = 0; i < NUM_BARS; i++)
      begin
         if (valid_masked[i])
            data_sel = data_sel | RxmReadData_i[i];
      end
   end

   // Collisions return zero data
   assign RxmReadData_o = valid_onehot ? data_sel : '0;

endmodule

// ==== design/msi_intf_export.sv ====
// Exported fields lag the shadows by one cycle except bus master enable, which is taken straight
module msi_intf_export
(
   input  logic                                   AvlClk_i,
   input  logic                                   rstn_i,
   input  logic [bridge_cfg_pkg::CFG_DATA_W-1:0]  dev_csr_i,
   input  logic [15:0]                            prmcsr_i,
   input  logic [15:0]                            msi_ctl_i,
   input  logic [bridge_cfg_pkg::MSIX_CTL_W-1:0]  msix_ctl_i,
   input  logic [bridge_cfg_pkg::MSI_ADDR_W-1:0]  msi_addr_i,
   input  logic [bridge_cfg_pkg::MSI_DATA_W-1:0]  msi_data_i,
   output logic [bridge_cfg_pkg::CFG_DATA_W-1:0]  DevCsr_o,
   output logic [bridge_cfg_pkg::MSI_INTFC_W-1:0] MsiIntfc_o,
   output logic [bridge_cfg_pkg::MSIX_CTL_W-1:0]  MsixIntfc_o
);

   import bridge_cfg_pkg::*;

   logic                  msi_en_reg;   // Only MSI control bit 0 is exported
   logic [MSI_ADDR_W-1:0] msi_addr_reg;
   logic [MSI_DATA_W-1:0] msi_data_reg;

   always_ff @(posedge AvlClk_i or negedge rstn_i)
   begin
      if (!rstn_i)
      begin
         DevCsr_o     <= '0;
         msi_en_reg   <= 1'b0;
         MsixIntfc_o  <= '0;
         msi_addr_reg <= '0;
         msi_data_reg <= '0;
      end
      else
      begin
         DevCsr_o     <= dev_csr_i;
         msi_en_reg   <= msi_ctl_i[0];
         MsixIntfc_o  <= msix_ctl_i;
         msi_addr_reg <= msi_addr_i;
         msi_data_reg <= msi_data_i;
      end
   end

   // Master enable, MSI enable, data, address from MSB down
   assign MsiIntfc_o = {prmcsr_i[MASTER_EN_BIT], msi_en_reg, msi_data_reg, msi_addr_reg};

endmodule

// ==== design/bridge_cfg_top.sv ====
// Only BAR0 and BAR2 masters are live, and all config outputs assume the hard IP sideband address map
module bridge_cfg_top
(
   input  logic                                   AvlClk_i,
   input  logic                                   Rstn_i,

   // Hard IP config sideband
   input  logic [bridge_cfg_pkg::CFG_ADDR_W-1:0]  CfgAddr_i,
   input  logic [bridge_cfg_pkg::CFG_DATA_W-1:0]  CfgCtl_i,

   // Per-BAR Avalon master returns
   input  logic [bridge_cfg_pkg::NUM_BARS-1:0]    RxmReadDataValid_i,
   input  logic [bridge_cfg_pkg::NUM_BARS-1:0]
                [bridge_cfg_pkg::RXM_DATA_W-1:0]  RxmReadData_i,
   input  logic [bridge_cfg_pkg::NUM_BARS-1:0]    RxmWaitRequest_i,
   output logic [bridge_cfg_pkg::NUM_BARS-1:0]    RxmWaitRequest_o,
   output logic                                   RxmReadDataValid_o,
   output logic [bridge_cfg_pkg::RXM_DATA_W-1:0]  RxmReadData_o,

   // Config and MSI exports
   output logic [bridge_cfg_pkg::BUSDEV_W-1:0]    BusDev_o,
   output logic [bridge_cfg_pkg::CFG_DATA_W-1:0]  DevCsr_o,
   output logic [bridge_cfg_pkg::MSI_INTFC_W-1:0] MsiIntfc_o,
   output logic [bridge_cfg_pkg::MSIX_CTL_W-1:0]  MsixIntfc_o
);

   import bridge_cfg_pkg::*;

   logic                  rstn_reg;   // Synchronized reset for every block
   logic [CFG_DATA_W-1:0] dev_csr;
   logic [15:0]           prmcsr;
   logic [15:0]           msi_ctl;
   logic [MSIX_CTL_W-1:0] msix_ctl;
   logic [MSI_ADDR_W-1:0] msi_addr;
   logic [MSI_DATA_W-1:0] msi_data;

   reset_sync u_reset_sync
   (
      .AvlClk_i   (AvlClk_i),
      .Rstn_i     (Rstn_i),
      .rstn_reg_o (rstn_reg)
   );

   cfg_shadow_capture u_cfg_shadow_capture
   (
      .AvlClk_i   (AvlClk_i),
      .rstn_i     (rstn_reg),
      .CfgAddr_i  (CfgAddr_i),
      .CfgCtl_i   (CfgCtl_i),
      .BusDev_o   (BusDev_o),
      .dev_csr_o  (dev_csr),
      .prmcsr_o   (prmcsr),
      .msi_ctl_o  (msi_ctl),
      .msix_ctl_o (msix_ctl),
      .msi_addr_o (msi_addr),
      .msi_data_o (msi_data)
   );

   rxm_read_return_mux u_rxm_read_return_mux
   (
      .RxmReadDataValid_i (RxmReadDataValid_i),
      .RxmReadData_i      (RxmReadData_i),
      .RxmWaitRequest_i   (RxmWaitRequest_i),
      .rxm_wait_request_o (RxmWaitRequest_o),
      .RxmReadDataValid_o (RxmReadDataValid_o),
      .RxmReadData_o      (RxmReadData_o)
   );

   msi_intf_export u_msi_intf_export
   (
      .AvlClk_i    (AvlClk_i),
      .rstn_i      (rstn_reg),
      .dev_csr_i   (dev_csr),
      .prmcsr_i    (prmcsr),
      .msi_ctl_i   (msi_ctl),
      .msix_ctl_i  (msix_ctl),
      .msi_addr_i  (msi_addr),
      .msi_data_i  (msi_data),
      .DevCsr_o    (DevCsr_o),
      .MsiIntfc_o  (MsiIntfc_o),
      .MsixIntfc_o (MsixIntfc_o)
   );

endmodule

// ==== dv/bridge_cfg_tb.sv ====
// Expects BAR0/BAR2 as the only live masters and stops at the first mismatch with $fatal
module bridge_cfg_tb;

   import bridge_cfg_pkg::*;

   localparam int CFG_ROUNDS     = 4;
   localparam int NUM_CFG_WRITES = CFG_ROUNDS * 8 + 4 + 8;   // Decoded, master enable, undecoded
   localparam int NUM_READS      = 7 + 16;
   localparam int WATCHDOG_TIME  = (NUM_CFG_WRITES + NUM_READS + 20) * 100 * 2;

   logic                                 AvlClk_i;
   logic                                 Rstn_i;
   logic [CFG_ADDR_W-1:0]                CfgAddr_i;
   logic [CFG_DATA_W-1:0]                CfgCtl_i;
   logic [NUM_BARS-1:0]                  RxmReadDataValid_i;
   logic [NUM_BARS-1:0][RXM_DATA_W-1:0]  RxmReadData_i;
   logic [NUM_BARS-1:0]                  RxmWaitRequest_i;
   logic [NUM_BARS-1:0]                  RxmWaitRequest_o;
   logic                                 RxmReadDataValid_o;
   logic [RXM_DATA_W-1:0]                RxmReadData_o;
   logic [BUSDEV_W-1:0]                  BusDev_o;
   logic [CFG_DATA_W-1:0]                DevCsr_o;
   logic [MSI_INTFC_W-1:0]               MsiIntfc_o;
   logic [MSIX_CTL_W-1:0]                MsixIntfc_o;

   // Model copy of the shadow registers
   logic [BUSDEV_W-1:0]    m_busdev;
   logic [31:0]            m_devcsr;
   logic [15:0]            m_prmcsr;
   logic [15:0]            m_msi_ctl;
   logic [15:0]            m_msix_ctl;
   logic [MSI_ADDR_W-1:0]  m_msi_addr;
   logic [MSI_DATA_W-1:0]  m_msi_data;

   // Model of the export stage, one edge behind the shadows
   logic [31:0]            exp_devcsr;
   logic [15:0]            exp_msix;
   logic [80:0]            exp_msi_low;

   integer                 seed;
   logic                   check_en;

   bridge_cfg_top UUT
   (
      .AvlClk_i           (AvlClk_i),
      .Rstn_i             (Rstn_i),
      .CfgAddr_i          (CfgAddr_i),
      .CfgCtl_i           (CfgCtl_i),
      .RxmReadDataValid_i (RxmReadDataValid_i),
      .RxmReadData_i      (RxmReadData_i),
      .RxmWaitRequest_i   (RxmWaitRequest_i),
      .RxmWaitRequest_o   (RxmWaitRequest_o),
      .RxmReadDataValid_o (RxmReadDataValid_o),
      .RxmReadData_o      (RxmReadData_o),
      .BusDev_o           (BusDev_o),
      .DevCsr_o           (DevCsr_o),
      .MsiIntfc_o         (MsiIntfc_o),
      .MsixIntfc_o        (MsixIntfc_o)
   );

   always #50 AvlClk_i = ~AvlClk_i;

   function automatic logic [31:0] rand_word();
      return $random(seed);
   endfunction

   // Sideband field map, addresses taken from the hard IP map
   function automatic void cfg_model_write(input logic [3:0] addr, input logic [31:0] data);
      case (addr)
         4'd0:  m_devcsr = {16'h0000, data[31:16]};
         4'd3:  m_prmcsr = data[23:8];
         4'd5:  m_msi_addr[11:0] = data[31:20];
         4'd9:  m_msi_addr[31:12] = data[31:12];
         4'd6:  m_msi_addr[43:32] = data[31:20];
         4'd11: m_msi_addr[63:44] = data[31:12];
         4'd13:
         begin
            m_msi_ctl  = data[15:0];
            m_msix_ctl = data[31:16];
         end
         4'd15:
         begin
            m_busdev   = data[12:0];
            m_msi_data = data[31:16];
         end
         default: ;   // Nothing captured
      endcase
   endfunction

   // Returns {valid, data} for the read return path
   function automatic logic [RXM_DATA_W:0] read_return_ref(
      input logic [NUM_BARS-1:0]                 valid,
      input logic [NUM_BARS-1:0][RXM_DATA_W-1:0] data);
      int                    hits;
      int                    i;
      logic [RXM_DATA_W-1:0] sel;
      hits = 0;
      sel  = '0;
      for (i = 0; i < NUM_BARS; i++)
      begin
         if (valid[i] && BAR_IMPLEMENTED[i])
         begin
            hits++;
            sel = data[i];
         end
      end
      if (hits != 1)
         sel = '0;   // Nothing returned or a collision
      return {hits != 0, sel};
   endfunction

   function automatic logic [NUM_BARS-1:0] wait_ref(input logic [NUM_BARS-1:0] wait_in);
      logic [NUM_BARS-1:0] res;
      int                  i;
      for (i = 0; i < NUM_BARS; i++)
         res[i] = BAR_IMPLEMENTED[i] ? wait_in[i] : 1'b1;
      return res;
   endfunction

   task automatic check_value(input string name, input logic [127:0] actual,
                              input logic [127:0] expected);
      if (actual !== expected)
      begin
         $display("** Error at time %0t: %s is 0x%0h, expected 0x%0h",
                  $time, name, actual, expected);
         $display("Test failed");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   task automatic cfg_write(input logic [3:0] addr, input logic [31:0] data);
      @(negedge AvlClk_i);
      CfgAddr_i = addr;
      CfgCtl_i  = data;
   endtask

   task automatic cfg_idle(input int cycles);
      repeat (cycles)
      begin
         @(negedge AvlClk_i);
         CfgAddr_i = 4'd1;   // Undecoded, holds every shadow
      end
   endtask

   task automatic read_drive(input logic [NUM_BARS-1:0] valid);
      logic [31:0] r;
      int          i;
      @(negedge AvlClk_i);
      r = rand_word();
      RxmReadDataValid_i = valid;
      RxmWaitRequest_i   = r[NUM_BARS-1:0];
      for (i = 0; i < NUM_BARS; i++)
         RxmReadData_i[i] = {rand_word(), rand_word()};
   endtask

   // Compare process, read return at the rising edge and registers at the falling edge
   initial
   begin
      logic [RXM_DATA_W:0] rr_exp;
      wait (check_en);
      forever
      begin
         @(posedge AvlClk_i);
         rr_exp = read_return_ref(RxmReadDataValid_i, RxmReadData_i);
         check_value("RxmReadDataValid_o", RxmReadDataValid_o, rr_exp[RXM_DATA_W]);
         check_value("RxmReadData_o", RxmReadData_o, rr_exp[RXM_DATA_W-1:0]);
         check_value("RxmWaitRequest_o", RxmWaitRequest_o, wait_ref(RxmWaitRequest_i));
         exp_devcsr  = m_devcsr;   // Export sees the shadow from before this edge
         exp_msix    = m_msix_ctl;
         exp_msi_low = {m_msi_ctl[0], m_msi_data, m_msi_addr};
         cfg_model_write(CfgAddr_i, CfgCtl_i);
         @(negedge AvlClk_i);
         check_value("BusDev_o", BusDev_o, m_busdev);
         check_value("MsiIntfc_o[81]", MsiIntfc_o[81], m_prmcsr[2]);
         check_value("DevCsr_o", DevCsr_o, exp_devcsr);
         check_value("MsiIntfc_o[80:0]", MsiIntfc_o[80:0], exp_msi_low);
         check_value("MsixIntfc_o", MsixIntfc_o, exp_msix);
      end
   end

   initial
   begin
      #(WATCHDOG_TIME);
      $display("Test failed");
      $fatal(1, "Watchdog expired before the test sequence completed");
   end

   // Stimulus
   initial
   begin
      logic [3:0]             order [8];
      logic [3:0]             tmp;
      logic [31:0]            r;
      logic [BUSDEV_W-1:0]    snap_busdev;
      logic [31:0]            snap_devcsr;
      logic [MSI_INTFC_W-1:0] snap_msi;
      logic [MSIX_CTL_W-1:0]  snap_msix;
      int                     i;
      int                     j;
      AvlClk_i           = 1'b0;
      Rstn_i             = 1'b0;
      CfgAddr_i          = 4'd1;
      CfgCtl_i           = '0;
      RxmReadDataValid_i = '0;
      RxmReadData_i      = '0;
      RxmWaitRequest_i   = '0;
      seed        = 32'h383a_73e6;
      check_en    = 1'b0;
      m_busdev    = '0;
      m_devcsr    = '0;
      m_prmcsr    = '0;
      m_msi_ctl   = '0;
      m_msix_ctl  = '0;
      m_msi_addr  = '0;
      m_msi_data  = '0;
      exp_devcsr  = '0;
      exp_msix    = '0;
      exp_msi_low = '0;

      repeat (2) @(negedge AvlClk_i);
      Rstn_i = 1'b1;
      repeat (2) @(negedge AvlClk_i);   // Internal reset released by now

      // Reset values
      check_value("BusDev_o", BusDev_o, '0);
      check_value("DevCsr_o", DevCsr_o, '0);
      check_value("MsiIntfc_o", MsiIntfc_o, '0);
      check_value("MsixIntfc_o", MsixIntfc_o, '0);
      check_value("RxmReadDataValid_o", RxmReadDataValid_o, 1'b0);
      check_value("RxmWaitRequest_o", RxmWaitRequest_o, 6'b111010);
      check_en = 1'b1;

      // Decoded addresses in a shuffled order each round
      repeat (CFG_ROUNDS)
      begin
         order = '{4'd0, 4'd3, 4'd5, 4'd6, 4'd9, 4'd11, 4'd13, 4'd15};
         for (i = 7; i > 0; i--)
         begin
            j = int'(rand_word() % 32'(i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
         end
         for (i = 0; i < 8; i++)
            cfg_write(order[i], rand_word());
      end
      cfg_idle(3);

      // Bus master enable toggling through the command register
      for (i = 0; i < 4; i++)
      begin
         r     = rand_word();
         r[10] = i[0];
         cfg_write(4'd3, r);
      end
      cfg_idle(3);

      snap_busdev = BusDev_o;
      snap_devcsr = DevCsr_o;
      snap_msi    = MsiIntfc_o;
      snap_msix   = MsixIntfc_o;
      order = '{4'd1, 4'd2, 4'd4, 4'd7, 4'd8, 4'd10, 4'd12, 4'd14};
      for (i = 0; i < 8; i++)
         cfg_write(order[i], rand_word());
      cfg_idle(3);
      check_value("BusDev_o", BusDev_o, snap_busdev);
      check_value("DevCsr_o", DevCsr_o, snap_devcsr);
      check_value("MsiIntfc_o", MsiIntfc_o, snap_msi);
      check_value("MsixIntfc_o", MsixIntfc_o, snap_msix);

      // Read returns, directed then random
      read_drive(6'b000001);
      read_drive(6'b000100);
      read_drive(6'b000010);
      read_drive(6'b001000);
      read_drive(6'b010000);
      read_drive(6'b100000);
      read_drive(6'b000101);   // BAR0 and BAR2 collide
      for (i = 0; i < NUM_READS - 7; i++)
      begin
         r = rand_word();
         read_drive(r[NUM_BARS-1:0]);
      end
      @(negedge AvlClk_i);
      RxmReadDataValid_i = '0;
      cfg_idle(3);

      $display("Test passed");
      $finish;
   end

endmodule

// ==== build.f ====
design/bridge_cfg_pkg.sv
design/reset_sync.sv
design/cfg_shadow_capture.sv
design/rxm_read_return_mux.sv
design/msi_intf_export.sv
design/bridge_cfg_top.sv
dv/bridge_cfg_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the bridge config testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f build.f \
   --top-module bridge_cfg_tb \
   -o bridge_cfg_sim

# A $fatal in the testbench gives a nonzero exit status
./obj_dir/bridge_cfg_sim
